// File: include/cps_crypt_cfg.svh
// Widths are fixed by the board; the range limit width must not exceed the address width
`ifndef CPS_CRYPT_CFG_SVH
`define CPS_CRYPT_CFG_SVH

// Word address seen by the opcode fetch
`define CRYPT_ADDR_W 24

// Ciphertext and plaintext word
`define CRYPT_DATA_W 16

// Bytes in one configuration stream
`define CRYPT_CFG_BYTES 20

// Range limit, compared with the top address bits
`define CRYPT_RANGE_W 16

`endif

// File: design/cps_crypt_pkg.sv
// Needs include/ on the include path; the unscramble table assumes a 160-bit config vector
`include "cps_crypt_cfg.svh"

package cps_crypt_pkg;

    localparam int CFG_W = `CRYPT_CFG_BYTES * 8;          // Raw shift register width

    typedef logic [`CRYPT_DATA_W-1:0] word_t;              // One program word

    typedef struct packed {
        logic [`CRYPT_ADDR_W-1:0] addr;                    // Word address
        word_t                    data;                    // Fetched ciphertext
    } fetch_t;

    typedef struct packed {
        word_t           data;                             // Word being decrypted
        logic            enc;                              // Address inside encrypted range
        logic [3:0][7:0] rkey;                             // Round keys 3..0
    } keyed_t;

    // Every 16-bit config word k draws on a 16-bit window of raw starting at base,
    // with its two lowest bits borrowed from the window below
    function automatic logic [CFG_W-1:0] key_unscramble(input logic [CFG_W-1:0] raw);
        logic [CFG_W-1:0] cfg;
        int               base;
        int               off;
        for (int k = 0; k < CFG_W / 16; k++) begin
            case (k)
                0:       base = 128;                       // Key words come in swapped pairs
                1:       base = 144;
                2:       base = 96;
                3:       base = 112;
                4:       base = 80;
                5:       base = 64;
                6:       base = 48;
                7:       base = 32;
                8:       base = 16;
                default: base = 0;                         // Range limit word
            endcase
            for (int j = 0; j < 16; j++) begin
                if (j >= 10) off = 25 - j;                 // Upper six bits reversed
                else if (j >= 2) off = 9 - j;              // Middle eight reversed
                else off = -7 - j;                         // Borrowed from previous window
                cfg[16*k + j] = raw[(base + off + CFG_W) % CFG_W];
            end
        end
        return cfg;
    endfunction

endpackage

// File: design/pipe_stage.sv
// Single entry register; holds one word and passes full throughput when drained every cycle
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [15:0]    // Carried word, any packed type
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;                                // Transfer into this stage

    // Free when empty or emptied this same cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;             // Refill or go empty
        end
    end

    // Payload only moves with a transfer, so it holds while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

// File: design/key_loader.sv
// One byte per rising edge of din_we; outputs are only meaningful once all 20 bytes are in
`timescale 1ns/1ps
`include "cps_crypt_cfg.svh"

module key_loader (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                din,        // Config byte
    input  logic                      din_we,     // Write strobe, level held by host
    output logic [`CRYPT_RANGE_W-1:0] addr_rng,   // Last encrypted upper address
    output logic [63:0]               key         // Eight key bytes
);
    import cps_crypt_pkg::*;

    logic             last_we;                    // Strobe seen on previous clk
    logic             we_rise;                    // First cycle of a strobe
    logic [CFG_W-1:0] raw;                        // Bytes as they arrived
    logic [CFG_W-1:0] cfg;                        // Unscrambled config vector

    assign we_rise = din_we && !last_we;          // Long strobes count once

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_we <= 1'b0;
        end else begin
            last_we <= din_we;
        end
    end

    // New byte enters at the top, so the first byte ends lowest
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw <= '0;
        end else if (we_rise) begin
            raw <= {din, raw[CFG_W-1:8]};
        end
    end

    // Pure wiring in hardware, the table is a bit permutation
    assign cfg = key_unscramble(raw);

    assign key      = cfg[63:0];                              // Low four config words
    assign addr_rng = cfg[CFG_W-1 -: `CRYPT_RANGE_W];         // Top config word

endmodule

// File: design/range_select.sv
// Stage 1; key and addr_rng are sampled with the word, so changes mid-stream affect later words
`timescale 1ns/1ps
`include "cps_crypt_cfg.svh"

module range_select (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [63:0]               key,
    input  logic [`CRYPT_RANGE_W-1:0] addr_rng,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  cps_crypt_pkg::fetch_t     in_fetch,
    output logic                      out_valid,
    input  logic                      out_ready,
    output cps_crypt_pkg::keyed_t     out_item
);
    import cps_crypt_pkg::*;

    keyed_t nxt;                               // Item before the stage register

    always_comb begin
        nxt.data = in_fetch.data;              // Ciphertext travels untouched here
        // Limit is inclusive
        nxt.enc  = in_fetch.addr[`CRYPT_ADDR_W-1 -: `CRYPT_RANGE_W] <= addr_rng;
        for (int i = 0; i < 4; i++) begin
            // Key byte i, its partner four up, and the low address byte
            nxt.rkey[i] = key[8*i +: 8] ^ key[8*(i+4) +: 8] ^ in_fetch.addr[7:0];
        end
    end

    pipe_stage #(
        .payload_t (keyed_t)
    ) u_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (nxt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_item)
    );

endmodule

// File: design/feistel_pair.sv
// Two rounds per pass; PASS must be 0 or 1, and the halves are fixed at 8 bits
`timescale 1ns/1ps

module feistel_pair #(
    parameter int PASS = 0                     // 0 does rounds 0-1, 1 does rounds 2-3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  cps_crypt_pkg::keyed_t in_item,
    output logic                  out_valid,
    input  logic                  out_ready,
    output cps_crypt_pkg::keyed_t out_item
);
    import cps_crypt_pkg::*;

    localparam int K0 = 2 * PASS;              // First round key used here

    keyed_t nxt;                               // Item before the stage register
    word_t  mid;                               // After the first round of the pair

    // F(r, k) = rotl3(r ^ k) + k, wraps at 8 bits
    function automatic logic [7:0] f_mix(input logic [7:0] r, input logic [7:0] k);
        logic [7:0] x;
        x = r ^ k;
        return {x[4:0], x[7:5]} + k;
    endfunction

    // Halves swap, the old high half takes the mixed low half
    function automatic word_t feistel_round(input word_t w, input logic [7:0] k);
        return {w[7:0], w[15:8] ^ f_mix(w[7:0], k)};
    endfunction

    assign mid = feistel_round(in_item.data, in_item.rkey[K0]);

    always_comb begin
        nxt = in_item;                         // Flag and keys ride along
        if (in_item.enc) begin
            nxt.data = feistel_round(mid, in_item.rkey[K0+1]);
        end
    end

    pipe_stage #(
        .payload_t (keyed_t)
    ) u_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (nxt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_item)
    );

endmodule

// File: design/cps_decrypt_top.sv
// Three cycles of latency; the key must be fully loaded before the first encrypted fetch
`timescale 1ns/1ps

module cps_decrypt_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            din,         // Config byte stream
    input  logic                  din_we,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  cps_crypt_pkg::fetch_t in_fetch,
    output logic                  out_valid,
    input  logic                  out_ready,
    output cps_crypt_pkg::word_t  out_word     // Plaintext opcode word
);
    import cps_crypt_pkg::*;

    logic [15:0] addr_rng;                     // Encrypted range limit
    logic [63:0] key;

    logic        sel_valid;                    // Stage 1 to pass 0
    logic        sel_ready;
    keyed_t      sel_item;
    logic        p0_valid;                     // Pass 0 to pass 1
    logic        p0_ready;
    keyed_t      p0_item;
    keyed_t      p1_item;                      // Last stage output

    key_loader u_keys (
        .clk      (clk),
        .rst      (rst),
        .din      (din),
        .din_we   (din_we),
        .addr_rng (addr_rng),
        .key      (key)
    );

    range_select u_sel (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .addr_rng  (addr_rng),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fetch  (in_fetch),
        .out_valid (sel_valid),
        .out_ready (sel_ready),
        .out_item  (sel_item)
    );

    feistel_pair #(.PASS(0)) pass0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .in_item   (sel_item),
        .out_valid (p0_valid),
        .out_ready (p0_ready),
        .out_item  (p0_item)
    );

    feistel_pair #(.PASS(1)) pass1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (p0_valid),
        .in_ready  (p0_ready),
        .in_item   (p0_item),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_item  (p1_item)
    );

    assign out_word = p1_item.data;            // Keys and flag end here

endmodule

// File: testbench/tb_cps_decrypt.sv
// Needs include/ on the include path; the model assumes the key is loaded before any fetch
`timescale 1ns/1ps
`include "cps_crypt_cfg.svh"

module tb_cps_decrypt;
    import cps_crypt_pkg::*;

    localparam int RAW_W  = `CRYPT_CFG_BYTES * 8;      // Config shift register width
    localparam int LIMIT  = 300;                       // Cycles allowed per wait
    localparam int TPUT_N = 16;                        // Words in the streaming run

    logic       clk;
    logic       rst;
    logic [7:0] din;
    logic       din_we;
    logic       in_valid;
    logic       in_ready;
    fetch_t     in_fetch;
    logic       out_valid;
    logic       out_ready;
    word_t      out_word;

    logic [RAW_W-1:0] shadow_raw;                      // Bytes as the host wrote them
    logic [RAW_W-1:0] mdl_cfg;
    logic [63:0]      mdl_key;
    logic [15:0]      mdl_rng;
    word_t            exp_q[$];                        // Scoreboard with the oldest word first
    word_t            exp_w;
    word_t            prev_word;
    logic             prev_stall;                      // Output held back last edge
    logic             rand_ready;                      // Random back-pressure on
    logic             tput;                            // Streaming latency check on
    int               first_in_cyc;
    int               tput_outs;
    int               cyc;
    int               check_errors;
    int               timeout_errors;

    cps_decrypt_top uut (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_we    (din_we),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fetch  (in_fetch),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Start of the raw window for config word k
    function automatic int window_base(input int k);
        if (k < 2) return 128 + 16 * k;
        if (k < 4) return 64 + 16 * k;
        return 144 - 16 * k;                           // Remaining words step down
    endfunction

    function automatic logic [RAW_W-1:0] unscramble_cfg(input logic [RAW_W-1:0] raw);
        logic [RAW_W-1:0] cfg;
        int               src;
        for (int k = 0; k < RAW_W / 16; k++) begin
            for (int j = 0; j < 16; j++) begin
                if (j < 2) src = window_base(k) - 7 - j;       // Two bits from below
                else if (j < 10) src = window_base(k) + 9 - j;
                else src = window_base(k) + 25 - j;
                if (src < 0) src = src + RAW_W;                // Wraps to the top
                cfg[16*k + j] = raw[src];
            end
        end
        return cfg;
    endfunction

    function automatic logic [7:0] mix_byte(input logic [7:0] r, input logic [7:0] k);
        logic [7:0] x;
        logic [7:0] rot;
        x   = r ^ k;
        rot = (x << 3) | (x >> 5);                     // Rotate left by 3
        return rot + k;
    endfunction

    function automatic word_t one_round(input word_t w, input logic [7:0] k);
        return {w[7:0], w[15:8] ^ mix_byte(w[7:0], k)};
    endfunction

    function automatic word_t expected_word(input fetch_t f);
        word_t      w;
        logic [7:0] rk;
        w = f.data;
        if (f.addr[`CRYPT_ADDR_W-1 -: `CRYPT_RANGE_W] <= mdl_rng) begin
            for (int i = 0; i < 4; i++) begin
                rk = mdl_key[8*i +: 8] ^ mdl_key[8*i+32 +: 8] ^ f.addr[7:0];
                w  = one_round(w, rk);
            end
        end
        return w;
    endfunction

    // Upper 16 bits picked inside or above the encrypted range
    function automatic logic [23:0] pick_addr(input logic in_range);
        logic [15:0] up;
        int          span;
        span = 65535 - int'(mdl_rng);
        if (!in_range && span > 0) up = 16'(32'(mdl_rng) + 32'd1 + ($urandom % 32'(span)));
        else up = 16'($urandom % (32'(mdl_rng) + 32'd1));
        return {up, 8'($urandom)};
    endfunction

    always @(negedge clk) begin
        if (rand_ready) out_ready = 1'($urandom);
        else out_ready = 1'b1;
    end

    // Scoreboard and handshake checks see the values from before the edge
    always @(posedge clk) begin
        if (rst) begin
            prev_stall = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (prev_stall) begin
                assert (out_valid && out_word == prev_word) else begin
                    $display("CHECK FAILED at %0t: output changed while stalled", $time);
                    check_errors++;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output word %h arrived with nothing outstanding", out_word);
                    check_errors++;
                end else begin
                    exp_w = exp_q.pop_front();
                    assert (out_word == exp_w) else begin
                        $display("CHECK FAILED at %0t: out_word %h, expected %h",
                                 $time, out_word, exp_w);
                        check_errors++;
                    end
                end
                if (tput) begin
                    assert (cyc == first_in_cyc + 3 + tput_outs) else begin
                        $display("CHECK FAILED at %0t: streaming output %0d off schedule",
                                 $time, tput_outs);
                        check_errors++;
                    end
                    tput_outs++;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_word(in_fetch));
                if (tput && first_in_cyc < 0) first_in_cyc = cyc;
            end
            prev_stall = out_valid && !out_ready;
            prev_word  = out_word;
        end
    end

    task automatic write_key_byte(input logic [7:0] b, input int hold);
        @(negedge clk);
        din    = b;
        din_we = 1'b1;
        repeat (hold) @(negedge clk);
        din_we = 1'b0;                                 // Low for one edge before the next
        shadow_raw = {b, shadow_raw[RAW_W-1:8]};
    endtask

    task automatic send_word(input logic [23:0] addr, input word_t data);
        int waited;
        @(negedge clk);
        in_valid      = 1'b1;
        in_fetch.addr = addr;
        in_fetch.data = data;
        waited        = 0;
        @(posedge clk);
        while (!in_ready && waited < LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!in_ready) begin
            $display("Timeout: in_ready stayed low for %0d cycles", LIMIT);
            timeout_errors++;
        end
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || out_valid) && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || out_valid) begin
            $display("Timeout: %0d words never left the pipeline", exp_q.size());
            timeout_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h75e));
        rst            = 1'b1;
        din            = 8'h00;
        din_we         = 1'b0;
        in_valid       = 1'b0;
        in_fetch       = '0;
        out_ready      = 1'b1;
        rand_ready     = 1'b0;
        tput           = 1'b0;
        shadow_raw     = '0;
        mdl_rng        = '0;
        mdl_key        = '0;
        first_in_cyc   = -1;
        tput_outs      = 0;
        cyc            = 0;
        check_errors   = 0;
        timeout_errors = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            $display("CHECK FAILED at %0t: wrong handshake state after reset", $time);
            check_errors++;
        end

        for (int b = 0; b < `CRYPT_CFG_BYTES; b++) begin
            write_key_byte(8'($urandom), (b % 4 == 1) ? 2 + int'($urandom % 3) : 1);
        end
        mdl_cfg = unscramble_cfg(shadow_raw);
        mdl_key = mdl_cfg[63:0];
        mdl_rng = mdl_cfg[RAW_W-1 -: 16];
        $display("Model key %h, range limit %h", mdl_key, mdl_rng);

        if (mdl_rng == 16'hFFFF) $display("Range covers every address, no pass-through words");
        else for (int i = 0; i < 8; i++) send_word(pick_addr(1'b0), word_t'($urandom));
        go_idle(1);
        wait_drain();

        send_word({mdl_rng, 8'($urandom)}, word_t'($urandom));  // Exactly at the limit
        send_word({16'h0000, 8'($urandom)}, word_t'($urandom));
        for (int i = 0; i < 8; i++) send_word(pick_addr(1'b1), word_t'($urandom));
        go_idle(1);
        wait_drain();

        rand_ready = 1'b1;
        for (int i = 0; i < 60; i++) begin
            send_word(pick_addr(1'($urandom)), word_t'($urandom));
            if ($urandom % 3 == 0) go_idle(1 + int'($urandom % 3));
        end
        go_idle(1);
        rand_ready = 1'b0;
        wait_drain();

        tput = 1'b1;                                   // Pipeline is empty here
        for (int i = 0; i < TPUT_N; i++) send_word(pick_addr(1'($urandom)), word_t'($urandom));
        go_idle(1);
        wait_drain();
        tput = 1'b0;
        assert (tput_outs == TPUT_N) else begin
            $display("CHECK FAILED at %0t: %0d streaming words out of %0d",
                     $time, tput_outs, TPUT_N);
            check_errors++;
        end
        assert (exp_q.size() == 0) else begin
            $display("CHECK FAILED at %0t: %0d words still expected", $time, exp_q.size());
            check_errors++;
        end

        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: cps_decrypt_top.f
+incdir+include
design/cps_crypt_pkg.sv
design/pipe_stage.sv
design/key_loader.sv
design/range_select.sv
design/feistel_pair.sv
design/cps_decrypt_top.sv
testbench/tb_cps_decrypt.sv

// File: Makefile
# Verilator build, run, lint and clean for the opcode decrypt pipeline

VERILATOR  ?= verilator
TOP        ?= tb_cps_decrypt
RTL_TOP    ?= cps_decrypt_top
FILELIST   ?= cps_decrypt_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
